//--- design/md_types_pkg.sv
/*
 * Bus widths, request and response structs and FSM state types shared by
 * the main-bus and Z80-bus blocks of the subsystem. Modules import it
 * inside their bodies and use scoped names in their port lists.
 */
`default_nettype none

package md_types_pkg;

	// ------------------------------------------------
	// Widths that carry a meaning
	// ------------------------------------------------
	// 68000 word address, byte address bits 23:1
	typedef logic [22:0] m68k_addr_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] z80_addr_t;
	// Byte address inside the 32 KB Z80 bus window
	typedef logic [14:0] zbus_addr_t;
	// Main-bus address bits 23:15 for Z80 accesses above 8000
	typedef logic [8:0]  bank_t;

	// ------------------------------------------------
	// CPU side strobes and data
	// ------------------------------------------------
	typedef struct packed {
		logic       as_n;
		logic       rnw;
		logic       uds_n;
		logic       lds_n;
		m68k_addr_t addr;
		word_t      wdata;
	} m68k_req_t;

	typedef struct packed {
		logic  dtack_n;
		word_t rdata;
	} m68k_rsp_t;

	typedef struct packed {
		logic      mreq_n;
		logic      rd_n;
		logic      wr_n;
		z80_addr_t addr;
		byte_t     wdata;
	} z80_req_t;

	typedef struct packed {
		logic  wait_n;
		byte_t rdata;
	} z80_rsp_t;

	// Cycle latched by the main-bus arbiter
	typedef struct packed {
		m68k_addr_t addr;
		word_t      wdata;
		logic       rnw;
		logic       uds_n;
		logic       lds_n;
	} mbus_t;

	typedef enum logic [2:0] {
		MB_IDLE,
		MB_SELECT,
		MB_RAM_READ,
		MB_ROM_READ,
		MB_ZBUS_PRE,
		MB_ZBUS_READ,
		MB_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_M68K,
		SRC_Z80
	} mbus_src_t;

	typedef enum logic [1:0] {
		ZB_IDLE,
		ZB_READ,
		ZB_FINISH
	} zbus_state_t;

	typedef enum logic {
		ZSRC_MBUS,
		ZSRC_Z80
	} zbus_src_t;

endpackage

`default_nettype wire

//--- design/md_map_pkg.sv
/*
 * Address map of the main bus and the Z80 bus. The decoders compare
 * slices of the latched address against these constants.
 */
`default_nettype none

package md_map_pkg;

	// ------------------------------------------------
	// Main bus, compared against byte address bits
	// ------------------------------------------------
	// ROM region ends below A00000 (bits 23:20)
	localparam logic [3:0]  ROM_LIMIT   = 4'hA;
	// Z80 bus window A00000-A0FFFF (bits 23:16)
	localparam logic [7:0]  ZBUS_PAGE   = 8'hA0;
	// Control page A11xxx (bits 23:12)
	localparam logic [11:0] CTRL_PAGE   = 12'hA11;
	// Register select in bits 11:8
	localparam logic [3:0]  CTRL_BUSREQ = 4'h1;
	localparam logic [3:0]  CTRL_RESET  = 4'h2;
	// Work RAM E00000-FFFFFF (bits 23:21)
	localparam logic [2:0]  RAM_TOP     = 3'b111;

	// Nothing drives the bus here
	localparam logic [15:0] OPEN_BUS    = 16'hFFFF;

	// ------------------------------------------------
	// Memory sizes
	// ------------------------------------------------
	localparam int ZRAM_AW = 13;
	localparam int WRAM_AW = 15;

	// ------------------------------------------------
	// Z80 side
	// ------------------------------------------------
	// Bank register page 6000-60FF (Z80-bus bits 14:8)
	localparam logic [6:0]  Z80_BANK_PAGE = 7'h60;
	// Last page served locally on the Z80 bus
	localparam logic [7:0]  Z80_LOCAL_TOP = 8'h7E;

endpackage

`default_nettype wire

//--- design/md_clk_enables.sv
/*
 * Clock enables derived from MCLK. The 68000 gets two phase enables per
 * bus clock and the Z80 a single enable, which stops while the 68000
 * holds the Z80 bus.
 */
`timescale 1ns/1ns
`default_nettype none

module md_clk_enables #(
	parameter int M68K_DIV = 7,
	parameter int Z80_DIV  = 15
) (
	input  logic MCLK,
	input  logic reset,
	input  logic z80_busreq_n,
	output logic m68k_phi1,
	output logic m68k_phi2,
	output logic z80_ce
);
	localparam int MW = $clog2(M68K_DIV);
	localparam int ZW = $clog2(Z80_DIV);

	logic [MW-1:0] phi1_cnt;
	logic [MW-1:0] phi2_cnt;
	logic [ZW-1:0] z80_cnt;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			phi1_cnt  <= '0;
			// Half a period ahead so phi2 lands between phi1 pulses
			phi2_cnt  <= MW'(M68K_DIV / 2);
			z80_cnt   <= '0;
			m68k_phi1 <= 1'b1;
			m68k_phi2 <= 1'b1;
			z80_ce    <= 1'b0;
		end else begin
			m68k_phi1 <= 1'b0;
			phi1_cnt  <= phi1_cnt + 1'b1;
			if (phi1_cnt == MW'(M68K_DIV - 1)) begin
				phi1_cnt  <= '0;
				m68k_phi1 <= 1'b1;
			end

			m68k_phi2 <= 1'b0;
			phi2_cnt  <= phi2_cnt + 1'b1;
			if (phi2_cnt == MW'(M68K_DIV - 1)) begin
				phi2_cnt  <= '0;
				m68k_phi2 <= 1'b1;
			end

			// Z80 stalls while its bus is requested
			z80_ce  <= 1'b0;
			z80_cnt <= z80_cnt + 1'b1;
			if (z80_cnt == ZW'(Z80_DIV - 1)) begin
				z80_cnt <= '0;
				z80_ce  <= z80_busreq_n;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/md_mbus_ctrl.sv
/*
 * Main-bus controller. Arbitrates the 68000 and the banked Z80 path,
 * decodes the latched cycle to cartridge ROM, Z80 bus, control registers
 * or work RAM, and returns the result as dtack_n or a Z80 response.
 * Holds the Z80 bus request and Z80 reset registers.
 */
`timescale 1ns/1ns
`default_nettype none

module md_mbus_ctrl (
	input  logic                      MCLK,
	input  logic                      reset,
	input  logic                      m68k_phi2,
	input  md_types_pkg::m68k_req_t   m68k_req,
	output md_types_pkg::m68k_rsp_t   m68k_rsp,
	input  md_types_pkg::z80_req_t    z80_req,
	input  logic                      z80_local,
	input  md_types_pkg::bank_t       bank,
	output logic                      mbus_z80_dtack_n,
	output md_types_pkg::byte_t       mbus_z80_rdata,
	output md_types_pkg::mbus_t       mbus,
	output logic                      wram_sel,
	input  md_types_pkg::word_t       wram_q,
	output logic                      zbus_sel,
	input  logic                      zbus_dtack_n,
	input  md_types_pkg::byte_t       zbus_rdata,
	output md_types_pkg::m68k_addr_t  rom_addr,
	output logic                      rom_req,
	input  logic                      rom_ack,
	input  md_types_pkg::word_t       rom_data,
	output logic                      z80_busreq_n,
	output logic                      z80_reset_n
);
	import md_types_pkg::*;
	import md_map_pkg::*;

	mbus_state_t state;
	mbus_src_t   src;
	word_t       data;
	logic        m68k_dtack_n;
	word_t       m68k_rdata;

	logic        z80_io;
	logic        m68k_go;
	logic        z80_go;
	m68k_addr_t  z80_maddr;

	logic        sel_rom;
	logic        sel_zbus;
	logic        sel_ctrl;
	logic        sel_ram;
	logic [3:0]  ctrl_reg;
	word_t       ctrl_rdata;

	// ------------------------------------------------
	// Arbitration
	// ------------------------------------------------
	assign z80_io = ~z80_req.mreq_n & (~z80_req.rd_n | ~z80_req.wr_n);

	// 68000 wins; a new cycle needs the previous dtack released
	assign m68k_go = (state == MB_IDLE) & ~m68k_req.as_n & m68k_dtack_n & m68k_phi2;
	assign z80_go  = (state == MB_IDLE) & ~m68k_go & z80_io & ~z80_local &
		mbus_z80_dtack_n;

	// 8000-FFFF goes through the bank, 7F00-7FFF lands in C000xx
	assign z80_maddr = z80_req.addr[15] ? {bank, z80_req.addr[14:1]} :
		{16'hC000, z80_req.addr[7:1]};

	always_ff @(posedge MCLK) begin
		if (m68k_go) begin
			mbus <= '{addr: m68k_req.addr, wdata: m68k_req.wdata, rnw: m68k_req.rnw,
				uds_n: m68k_req.uds_n, lds_n: m68k_req.lds_n};
		end else if (z80_go) begin
			// Z80 byte goes on both lanes, strobe picked by A0
			mbus <= '{addr: z80_maddr, wdata: {z80_req.wdata, z80_req.wdata},
				rnw: z80_req.wr_n, uds_n: z80_req.addr[0], lds_n: ~z80_req.addr[0]};
		end
	end

	// ------------------------------------------------
	// Address decode
	// ------------------------------------------------
	// Cartridge is 000000-3FFFFF, the rest below A00000 is empty expansion space
	assign sel_rom  = (mbus.addr[22:19] < ROM_LIMIT) && (mbus.addr[22:21] == 2'b00);
	assign sel_zbus = mbus.addr[22:15] == ZBUS_PAGE;
	assign ctrl_reg = mbus.addr[10:7];
	assign sel_ctrl = (mbus.addr[22:11] == CTRL_PAGE) && (mbus.addr[6:0] == 7'd0) &&
		((ctrl_reg == CTRL_BUSREQ) || (ctrl_reg == CTRL_RESET));
	assign sel_ram  = mbus.addr[22:20] == RAM_TOP;

	assign ctrl_rdata = {7'd0, z80_busreq_n, 8'd0};
	assign rom_addr   = mbus.addr;
	assign m68k_rsp   = '{dtack_n: m68k_dtack_n, rdata: m68k_rdata};

	// ------------------------------------------------
	// Cycle FSM
	// ------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state            <= MB_IDLE;
			src              <= SRC_NONE;
			m68k_dtack_n     <= 1'b1;
			mbus_z80_dtack_n <= 1'b1;
			wram_sel         <= 1'b0;
			zbus_sel         <= 1'b0;
			rom_req          <= 1'b0;
			z80_busreq_n     <= 1'b1;
			z80_reset_n      <= 1'b0;
		end else begin
			// Acknowledges drop once the master ends its cycle
			if (m68k_req.as_n)
				m68k_dtack_n <= 1'b1;
			if (!z80_io)
				mbus_z80_dtack_n <= 1'b1;

			case (state)
			MB_IDLE: begin
				data <= OPEN_BUS;
				if (m68k_go) begin
					src   <= SRC_M68K;
					state <= MB_SELECT;
				end else if (z80_go) begin
					src   <= SRC_Z80;
					state <= MB_SELECT;
				end
			end

			MB_SELECT: begin
				// Unmapped cycles finish with open bus data
				state <= MB_FINISH;
				if (sel_rom && mbus.rnw) begin
					rom_req <= ~rom_ack;
					state   <= MB_ROM_READ;
				end else if (sel_zbus) begin
					state <= MB_ZBUS_PRE;
				end else if (sel_ctrl) begin
					data <= ctrl_rdata;
					if (!mbus.rnw && !mbus.uds_n) begin
						if (ctrl_reg == CTRL_BUSREQ)
							z80_busreq_n <= ~mbus.wdata[8];
						if (ctrl_reg == CTRL_RESET)
							z80_reset_n <= mbus.wdata[8];
					end
				end else if (sel_ram) begin
					wram_sel <= 1'b1;
					state    <= MB_RAM_READ;
				end
			end

			MB_RAM_READ: begin
				// One select cycle, then the RAM output is valid
				if (wram_sel) begin
					wram_sel <= 1'b0;
				end else begin
					data  <= wram_q;
					state <= MB_FINISH;
				end
			end

			MB_ROM_READ:
				if (rom_req == rom_ack) begin
					data  <= rom_data;
					state <= MB_FINISH;
				end

			// Lets the latched cycle settle before the Z80 bus samples it
			MB_ZBUS_PRE: begin
				zbus_sel <= 1'b1;
				state    <= MB_ZBUS_READ;
			end

			MB_ZBUS_READ:
				if (!zbus_dtack_n) begin
					zbus_sel <= 1'b0;
					data     <= {zbus_rdata, zbus_rdata};
					state    <= MB_FINISH;
				end

			MB_FINISH: begin
				if (src == SRC_M68K) begin
					m68k_rdata   <= data;
					m68k_dtack_n <= 1'b0;
				end else if (src == SRC_Z80) begin
					// Odd Z80 address takes the low byte
					mbus_z80_rdata   <= mbus.uds_n ? data[7:0] : data[15:8];
					mbus_z80_dtack_n <= 1'b0;
				end
				src   <= SRC_NONE;
				state <= MB_IDLE;
			end

			default:
				state <= MB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/md_work_ram.sv
/*
 * 64 KB 68000 work RAM as two byte planes. Writes follow the byte strobes
 * of the latched cycle, reads return a word one cycle after select.
 */
`timescale 1ns/1ns
`default_nettype none

module md_work_ram (
	input  logic                 MCLK,
	input  md_types_pkg::mbus_t  mbus,
	input  logic                 wram_sel,
	output md_types_pkg::word_t  wram_q
);
	import md_types_pkg::*;
	import md_map_pkg::*;

	// Plane 1 is the upper byte, plane 0 the lower
	byte_t              plane [2][2**WRAM_AW];
	logic [WRAM_AW-1:0] waddr;
	logic [1:0]         lane_we;

	assign waddr   = mbus.addr[WRAM_AW-1:0];
	assign lane_we = {~mbus.uds_n, ~mbus.lds_n} & {2{wram_sel & ~mbus.rnw}};

	always_ff @(posedge MCLK) begin
		for (int i = 0; i < 2; i++) begin
			if (lane_we[i])
				plane[i][waddr] <= mbus.wdata[8*i +: 8];
		end
		if (wram_sel)
			wram_q <= {plane[1][waddr], plane[0][waddr]};
	end

endmodule

`default_nettype wire

//--- design/md_zbus_ctrl.sv
/*
 * Z80 bus controller. Shares the Z80 bus between main-bus cycles in the
 * A00000 window and local Z80 accesses, holds the 8 KB Z80 RAM and the
 * bank register, and merges both response paths into the Z80 response.
 */
`timescale 1ns/1ns
`default_nettype none

module md_zbus_ctrl (
	input  logic                     MCLK,
	input  logic                     reset,
	input  md_types_pkg::mbus_t      mbus,
	input  logic                     zbus_sel,
	output logic                     zbus_dtack_n,
	output md_types_pkg::byte_t      zbus_rdata,
	input  md_types_pkg::z80_req_t   z80_req,
	output logic                     z80_local,
	output md_types_pkg::z80_rsp_t   z80_rsp,
	input  logic                     mbus_z80_dtack_n,
	input  md_types_pkg::byte_t      mbus_z80_rdata,
	input  logic                     z80_busreq_n,
	input  logic                     z80_reset_n,
	output md_types_pkg::bank_t      bank
);
	import md_types_pkg::*;
	import md_map_pkg::*;

	zbus_state_t zstate;
	zbus_src_t   zsrc;
	zbus_addr_t  zbus_a;
	byte_t       zbus_do;
	logic        zbus_we;
	byte_t       zbus_di;

	logic        z80_io;
	logic        z80_sel;
	logic        z80_dtack_n;
	byte_t       z80_rdata;
	logic        bus_free;

	byte_t       zram [2**ZRAM_AW];
	byte_t       zram_q;
	logic        zram_sel;
	logic        bank_sel;

	// ------------------------------------------------
	// Decode
	// ------------------------------------------------
	// Z80 serves 0000-7EFF itself, everything else goes to the main bus
	assign z80_local = z80_req.addr[15:8] <= Z80_LOCAL_TOP;
	assign z80_io    = ~z80_req.mreq_n & (~z80_req.rd_n | ~z80_req.wr_n);
	assign z80_sel   = z80_local & z80_io;

	// The 68000 owns the bus only with busreq set and the Z80 out of reset
	assign bus_free = ~z80_busreq_n & z80_reset_n;

	// RAM 0000-1FFF, mirrored at 2000-3FFF
	assign zram_sel = ~zbus_a[14];
	assign bank_sel = zbus_a[14:8] == Z80_BANK_PAGE;
	assign zbus_di  = zram_sel ? zram_q : OPEN_BUS[7:0];

	always_ff @(posedge MCLK) begin
		if (zbus_we && zram_sel)
			zram[zbus_a[ZRAM_AW-1:0]] <= zbus_do;
		zram_q <= zram[zbus_a[ZRAM_AW-1:0]];
	end

	// Nine writes of bit 0 build the bank, first write ends up in the LSB
	always_ff @(posedge MCLK) begin
		if (reset)
			bank <= '0;
		else if (bank_sel && zbus_we)
			bank <= {zbus_do[0], bank[8:1]};
	end

	// ------------------------------------------------
	// Bus FSM
	// ------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate       <= ZB_IDLE;
			zsrc         <= ZSRC_MBUS;
			zbus_we      <= 1'b0;
			zbus_dtack_n <= 1'b1;
			z80_dtack_n  <= 1'b1;
		end else begin
			zbus_we <= 1'b0;
			if (!zbus_sel)
				zbus_dtack_n <= 1'b1;
			if (!z80_sel)
				z80_dtack_n <= 1'b1;

			case (zstate)
			ZB_IDLE:
				if (zbus_sel && zbus_dtack_n) begin
					zbus_a  <= {mbus.addr[13:0], mbus.uds_n};
					zbus_do <= !mbus.uds_n ? mbus.wdata[15:8] : mbus.wdata[7:0];
					// Writes without the bus grant are dropped
					zbus_we <= ~mbus.rnw & bus_free;
					zsrc    <= ZSRC_MBUS;
					zstate  <= ZB_READ;
				end else if (z80_sel && z80_dtack_n) begin
					zbus_a  <= z80_req.addr[14:0];
					zbus_do <= z80_req.wdata;
					zbus_we <= ~z80_req.wr_n;
					zsrc    <= ZSRC_Z80;
					zstate  <= ZB_READ;
				end

			ZB_READ:
				zstate <= ZB_FINISH;

			ZB_FINISH: begin
				if (zsrc == ZSRC_MBUS) begin
					zbus_rdata   <= bus_free ? zbus_di : OPEN_BUS[7:0];
					zbus_dtack_n <= 1'b0;
				end else begin
					z80_rdata   <= zbus_di;
					z80_dtack_n <= 1'b0;
				end
				zstate <= ZB_IDLE;
			end

			default:
				zstate <= ZB_IDLE;
			endcase
		end
	end

	// Wait stays high when the Z80 is idle or either path has answered
	assign z80_rsp = '{wait_n: ~mbus_z80_dtack_n | ~z80_dtack_n | ~z80_io,
		rdata: !z80_dtack_n ? z80_rdata : mbus_z80_rdata};

endmodule

`default_nettype wire

//--- design/md_bus_top.sv
/*
 * Top level of the main-bus and Z80-bus subsystem. Both CPUs and the
 * cartridge sit outside and connect through the ports here.
 */
`timescale 1ns/1ns
`default_nettype none

module md_bus_top #(
	parameter int M68K_DIV = 7,
	parameter int Z80_DIV  = 15
) (
	input  logic                      MCLK,
	input  logic                      reset,
	input  md_types_pkg::m68k_req_t   m68k_req,
	output md_types_pkg::m68k_rsp_t   m68k_rsp,
	input  md_types_pkg::z80_req_t    z80_req,
	output md_types_pkg::z80_rsp_t    z80_rsp,
	output md_types_pkg::m68k_addr_t  rom_addr,
	output logic                      rom_req,
	input  logic                      rom_ack,
	input  md_types_pkg::word_t       rom_data,
	output logic                      m68k_phi1,
	output logic                      m68k_phi2,
	output logic                      z80_ce,
	output logic                      z80_busreq_n,
	output logic                      z80_reset_n
);
	import md_types_pkg::*;

	mbus_t mbus;
	logic  wram_sel;
	word_t wram_q;
	logic  zbus_sel;
	logic  zbus_dtack_n;
	byte_t zbus_rdata;
	logic  z80_local;
	bank_t bank;
	logic  mbus_z80_dtack_n;
	byte_t mbus_z80_rdata;

	md_clk_enables #(
		.M68K_DIV(M68K_DIV),
		.Z80_DIV(Z80_DIV)
	) u_clk_enables (
		.MCLK(MCLK),
		.reset(reset),
		.z80_busreq_n(z80_busreq_n),
		.m68k_phi1(m68k_phi1),
		.m68k_phi2(m68k_phi2),
		.z80_ce(z80_ce)
	);

	md_mbus_ctrl u_mbus_ctrl (
		.MCLK(MCLK),
		.reset(reset),
		.m68k_phi2(m68k_phi2),
		.m68k_req(m68k_req),
		.m68k_rsp(m68k_rsp),
		.z80_req(z80_req),
		.z80_local(z80_local),
		.bank(bank),
		.mbus_z80_dtack_n(mbus_z80_dtack_n),
		.mbus_z80_rdata(mbus_z80_rdata),
		.mbus(mbus),
		.wram_sel(wram_sel),
		.wram_q(wram_q),
		.zbus_sel(zbus_sel),
		.zbus_dtack_n(zbus_dtack_n),
		.zbus_rdata(zbus_rdata),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	md_work_ram u_work_ram (
		.MCLK(MCLK),
		.mbus(mbus),
		.wram_sel(wram_sel),
		.wram_q(wram_q)
	);

	md_zbus_ctrl u_zbus_ctrl (
		.MCLK(MCLK),
		.reset(reset),
		.mbus(mbus),
		.zbus_sel(zbus_sel),
		.zbus_dtack_n(zbus_dtack_n),
		.zbus_rdata(zbus_rdata),
		.z80_req(z80_req),
		.z80_local(z80_local),
		.z80_rsp(z80_rsp),
		.mbus_z80_dtack_n(mbus_z80_dtack_n),
		.mbus_z80_rdata(mbus_z80_rdata),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n),
		.bank(bank)
	);

endmodule

`default_nettype wire

//--- dv/md_bus_chk.sv
/*
 * Concurrent checks on the main-bus controller handshakes. Bound into
 * md_mbus_ctrl from the testbench top.
 */
`timescale 1ns/1ns
`default_nettype none

module md_bus_chk (
	input logic                        MCLK,
	input logic                        reset,
	input md_types_pkg::m68k_req_t     m68k_req,
	input md_types_pkg::m68k_rsp_t     m68k_rsp,
	input md_types_pkg::mbus_state_t   state,
	input logic                        rom_req,
	input logic                        wram_sel,
	input logic                        zbus_sel
);
	import md_types_pkg::*;

	// dtack_n holds low while the 68000 keeps as_n low
	dtack_hold: assert property (@(posedge MCLK) disable iff (reset)
		(!m68k_rsp.dtack_n && !m68k_req.as_n) |=> (!m68k_rsp.dtack_n || m68k_req.as_n))
		else $error("dtack_n released while as_n still low");

	// A ROM request toggles only when SELECT moves into ROM_READ
	rom_toggle: assert property (@(posedge MCLK) disable iff (reset)
		!$stable(rom_req) |-> ($past(state) == MB_SELECT && state == MB_ROM_READ))
		else $error("rom_req toggled outside ROM_READ entry");

	one_select: assert property (@(posedge MCLK) disable iff (reset)
		!(wram_sel && zbus_sel))
		else $error("wram_sel and zbus_sel high together");

endmodule

`default_nettype wire

//--- dv/md_bus_tb.sv
/*
 * Testbench for md_bus_top. Plays the 68000, the Z80 and the cartridge,
 * keeps a model of both RAMs, the bank and the control registers, and
 * compares every completed read against it.
 */
`timescale 1ns/1ns
`default_nettype none

module md_bus_tb;
	import md_types_pkg::*;

	// About 200 bus cycles of up to 20 clocks each, plenty of headroom
	localparam int CYCLE_LIMIT = 20000;

	logic       MCLK;
	logic       reset;
	m68k_req_t  m68k_req;
	m68k_rsp_t  m68k_rsp;
	z80_req_t   z80_req;
	z80_rsp_t   z80_rsp;
	m68k_addr_t rom_addr;
	logic       rom_req;
	logic       rom_ack;
	word_t      rom_data;
	logic       m68k_phi1;
	logic       m68k_phi2;
	logic       z80_ce;
	logic       z80_busreq_n;
	logic       z80_reset_n;

	// Reference state
	word_t      wram_m [32768];
	byte_t      zram_m [8192];
	logic       busreq_n_m;
	logic       reset_n_m;

	// Cartridge responder
	logic       rom_busy;
	int         rom_delay;
	m68k_addr_t rom_seen;

	int          cycles;
	int          errors;
	string       name_q [$];
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];

	md_bus_top #(
		.M68K_DIV(7),
		.Z80_DIV(15)
	) DUT (
		.MCLK(MCLK),
		.reset(reset),
		.m68k_req(m68k_req),
		.m68k_rsp(m68k_rsp),
		.z80_req(z80_req),
		.z80_rsp(z80_rsp),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data),
		.m68k_phi1(m68k_phi1),
		.m68k_phi2(m68k_phi2),
		.z80_ce(z80_ce),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	bind md_mbus_ctrl md_bus_chk u_chk (
		.MCLK(MCLK),
		.reset(reset),
		.m68k_req(m68k_req),
		.m68k_rsp(m68k_rsp),
		.state(state),
		.rom_req(rom_req),
		.wram_sel(wram_sel),
		.zbus_sel(zbus_sel)
	);

	always #5 MCLK = ~MCLK;

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic word_t wram_word(int off);
		return wram_m[off];
	endfunction

	// Cartridge answers with the inverted low word-address bits
	function automatic word_t rom_word(m68k_addr_t a);
		return ~a[15:0];
	endfunction

	function automatic word_t zbus_word(int n);
		byte_t b;
		b = (!busreq_n_m && reset_n_m) ? zram_m[n % 8192] : 8'hFF;
		return {b, b};
	endfunction

	function automatic byte_t banked_byte(bank_t bk, logic [14:0] off);
		word_t w;
		w = rom_word({bk, off[14:1]});
		return off[0] ? w[7:0] : w[15:8];
	endfunction

	function automatic word_t ctrl_word();
		return {7'd0, busreq_n_m, 8'd0};
	endfunction

	// --------------------------------------------------
	// Compare process and limits
	// --------------------------------------------------
	task automatic expect_val(string name, logic [31:0] got, logic [31:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	always @(negedge MCLK) begin
		string       nm;
		logic [31:0] g;
		logic [31:0] e;
		while (got_q.size() > 0) begin
			nm = name_q.pop_front();
			g  = got_q.pop_front();
			e  = exp_q.pop_front();
			assert (g == e) else begin
				errors++;
				$display("** Error at %0t: %s got %h expected %h", $time, nm, g, e);
				$display("*** FAILED ***");
				$fatal(1);
			end
		end
	end

	always @(posedge MCLK) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout: the bus tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	// Acknowledge each toggled request after 0 to 5 cycles
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack  <= 1'b0;
			rom_busy <= 1'b0;
		end else if (!rom_busy && rom_req != rom_ack) begin
			rom_busy  <= 1'b1;
			rom_delay <= $urandom % 6;
		end else if (rom_busy) begin
			if (rom_delay == 0) begin
				rom_data <= ~rom_addr[15:0];
				rom_ack  <= rom_req;
				rom_seen <= rom_addr;
				rom_busy <= 1'b0;
			end else begin
				rom_delay <= rom_delay - 1;
			end
		end
	end

	// --------------------------------------------------
	// Bus master tasks
	// --------------------------------------------------
	task automatic m68k_cycle(input logic rnw, input logic [23:0] baddr, input logic uds_n,
		input logic lds_n, input word_t wdata, output word_t rdata);
		@(posedge MCLK);
		m68k_req <= '{as_n: 1'b0, rnw: rnw, uds_n: uds_n, lds_n: lds_n,
			addr: baddr[23:1], wdata: wdata};
		@(negedge MCLK);
		while (m68k_rsp.dtack_n)
			@(negedge MCLK);
		rdata = m68k_rsp.rdata;
		@(posedge MCLK);
		m68k_req.as_n <= 1'b1;
		@(negedge MCLK);
		while (!m68k_rsp.dtack_n)
			@(negedge MCLK);
	endtask

	task automatic z80_cycle(input logic rd, input z80_addr_t addr, input byte_t wdata,
		output byte_t rdata);
		@(posedge MCLK);
		z80_req <= '{mreq_n: 1'b0, rd_n: ~rd, wr_n: rd, addr: addr, wdata: wdata};
		@(negedge MCLK);
		while (!z80_rsp.wait_n)
			@(negedge MCLK);
		rdata = z80_rsp.rdata;
		@(posedge MCLK);
		z80_req <= '{mreq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, addr: addr, wdata: wdata};
		repeat (2) @(posedge MCLK);
	endtask

	task automatic wram_write(int off, word_t d, logic uds_n, logic lds_n);
		word_t unused;
		m68k_cycle(1'b0, 24'hFF0000 + 24'(off * 2), uds_n, lds_n, d, unused);
		if (!uds_n)
			wram_m[off][15:8] = d[15:8];
		if (!lds_n)
			wram_m[off][7:0] = d[7:0];
	endtask

	// Byte access in the A00000 window, strobe picked by the byte address
	task automatic zbus_access(logic rnw, logic [23:0] baddr, byte_t d, output word_t q);
		m68k_cycle(rnw, baddr, baddr[0], ~baddr[0], {d, d}, q);
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		int          pool [16];
		int          p1;
		int          p2;
		int          p3;
		int          n;
		int          idx [12];
		word_t       q;
		byte_t       zq;
		byte_t       v;
		bank_t       bk;
		logic [14:0] off;
		m68k_addr_t  a;

		MCLK       = 1'b0;
		reset      = 1'b1;
		m68k_req   = '{as_n: 1'b1, rnw: 1'b1, uds_n: 1'b1, lds_n: 1'b1, addr: '0, wdata: '0};
		z80_req    = '{mreq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, addr: '0, wdata: '0};
		rom_ack    = 1'b0;
		rom_data   = '0;
		rom_busy   = 1'b0;
		rom_delay  = 0;
		cycles     = 0;
		errors     = 0;
		busreq_n_m = 1'b1;
		reset_n_m  = 1'b0;
		void'($urandom(33));

		repeat (8) @(posedge MCLK);
		reset <= 1'b0;

		// Reset levels, then enable pulse counts
		@(negedge MCLK);
		expect_val("dtack_n", 32'(m68k_rsp.dtack_n), 1);
		expect_val("wait_n", 32'(z80_rsp.wait_n), 1);
		expect_val("z80_reset_n", 32'(z80_reset_n), 0);
		expect_val("z80_busreq_n", 32'(z80_busreq_n), 1);
		// No ROM request pending
		expect_val("rom_req", 32'(rom_req), 32'(rom_ack));
		p1 = 0;
		p2 = 0;
		p3 = 0;
		repeat (210) begin
			@(negedge MCLK);
			if (m68k_phi1)
				p1++;
			if (z80_ce)
				p2++;
			if (m68k_phi2)
				p3++;
		end
		expect_val("m68k_phi1 pulses", p1, 30);
		expect_val("z80_ce pulses", p2, 14);
		expect_val("m68k_phi2 pulses", p3, 30);

		// Work RAM
		foreach (pool[i]) begin
			pool[i] = $urandom % 32768;
			wram_write(pool[i], 16'($urandom), 1'b0, 1'b0);
		end
		repeat (24) begin
			n = $urandom % 3;
			wram_write(pool[$urandom % 16], 16'($urandom), n == 2, n == 1);
		end
		foreach (pool[i]) begin
			m68k_cycle(1'b1, 24'hFF0000 + 24'(pool[i] * 2), 1'b0, 1'b0, '0, q);
			expect_val("wram rdata", 32'(q), 32'(wram_word(pool[i])));
		end

		// Cartridge ROM and unmapped space
		repeat (20) begin
			a = m68k_addr_t'($urandom % 32'h200000);
			m68k_cycle(1'b1, {a, 1'b0}, 1'b0, 1'b0, '0, q);
			expect_val("rom rdata", 32'(q), 32'(rom_word(a)));
			expect_val("rom_addr", 32'(rom_seen), 32'(a));
		end
		repeat (8) begin
			a = m68k_addr_t'(32'h200000 + $urandom % 32'h300000);
			m68k_cycle(1'b1, {a, 1'b0}, 1'b0, 1'b0, '0, q);
			expect_val("open bus rdata", 32'(q), 32'hFFFF);
		end

		// Z80 bus from the 68000, before and after the grant
		m68k_cycle(1'b1, 24'hA00000, 1'b0, 1'b0, '0, q);
		expect_val("ungranted zbus rdata", 32'(q), 32'(zbus_word(0)));
		m68k_cycle(1'b0, 24'hA11100, 1'b0, 1'b0, 16'h0100, q);
		busreq_n_m = 1'b0;
		m68k_cycle(1'b0, 24'hA11200, 1'b0, 1'b0, 16'h0100, q);
		reset_n_m = 1'b1;
		m68k_cycle(1'b1, 24'hA11100, 1'b0, 1'b0, '0, q);
		expect_val("ctrl rdata", 32'(q), 32'(ctrl_word()));
		foreach (idx[i]) begin
			idx[i] = $urandom % 8192;
			v = 8'($urandom);
			zbus_access(1'b0, 24'hA00000 + 24'(idx[i]), v, q);
			zram_m[idx[i]] = v;
		end
		foreach (idx[i]) begin
			zbus_access(1'b1, 24'hA00000 + 24'(idx[i]), '0, q);
			expect_val("zbus rdata", 32'(q), 32'(zbus_word(idx[i])));
			zbus_access(1'b1, 24'hA02000 + 24'(idx[i]), '0, q);
			expect_val("zbus mirror rdata", 32'(q), 32'(zbus_word(idx[i])));
		end

		// Z80 local RAM, bank setup and banked ROM reads
		repeat (10) begin
			n = $urandom % 8192;
			v = 8'($urandom);
			z80_cycle(1'b0, z80_addr_t'(n), v, zq);
			zram_m[n] = v;
			z80_cycle(1'b1, z80_addr_t'(n), '0, zq);
			expect_val("z80 ram rdata", 32'(zq), 32'(zram_m[n]));
		end
		bk = bank_t'($urandom % 128);
		for (int i = 0; i < 9; i++)
			z80_cycle(1'b0, 16'h6000, {7'd0, bk[i]}, zq);
		repeat (8) begin
			off = 15'($urandom);
			z80_cycle(1'b1, {1'b1, off}, '0, zq);
			expect_val("banked rdata", 32'(zq), 32'(banked_byte(bk, off)));
			expect_val("banked rom_addr", 32'(rom_seen), 32'({bk, off[14:1]}));
		end

		@(negedge MCLK);
		while (got_q.size() > 0)
			@(negedge MCLK);
		@(posedge MCLK);
		if (errors == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- md_bus.f
design/md_types_pkg.sv
design/md_map_pkg.sv
design/md_clk_enables.sv
design/md_mbus_ctrl.sv
design/md_work_ram.sv
design/md_zbus_ctrl.sv
design/md_bus_top.sv
dv/md_bus_chk.sv
dv/md_bus_tb.sv

//--- Makefile
# Verilator build and run for the md_bus subsystem testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f md_bus.f --top-module md_bus_tb

run: compile
	./obj_dir/Vmd_bus_tb | tee /dev/stderr | grep -q "\*\*\* PASSED \*\*\*"

clean:
	rm -rf obj_dir
